// File: logic/bridge_pkg.sv
package bridge_pkg;

   // Bus widths
   localparam int unsigned AddrWidth       = 32;
   localparam int unsigned NarrowDataWidth = 32;
   localparam int unsigned WideDataWidth   = 64;

   typedef logic [AddrWidth-1:0]           addr_t;
   typedef logic [NarrowDataWidth-1:0]     narrow_data_t;
   typedef logic [NarrowDataWidth/8-1:0]   narrow_strb_t;
   typedef logic [WideDataWidth-1:0]       wide_data_t;
   typedef logic [WideDataWidth/8-1:0]     wide_strb_t;

   typedef struct packed {
      addr_t        addr;
      logic         write;
      narrow_data_t data;
      narrow_strb_t strb;
   } narrow_req_t;

   typedef struct packed {
      addr_t      addr;
      logic       write;
      wide_data_t data;
      wide_strb_t strb;
   } wide_req_t;

   typedef struct packed {
      narrow_data_t data;
      logic         err;
   } narrow_rsp_t;

   typedef struct packed {
      wide_data_t data;
      logic       err;
   } wide_rsp_t;

   localparam int unsigned DefLogDepth   = 2;
   localparam int unsigned DefSyncStages = 3;
   localparam int unsigned DefMaxPending = 4;

   // Selects the upper 32-bit half of a 64-bit word
   localparam int unsigned LaneBit = 2;

endpackage

// File: logic/bus_if.sv
interface bus_if #(
   parameter type req_t = logic,
   parameter type rsp_t = logic
) ();

   logic req_valid;
   logic req_ready;
   req_t req;

   logic rsp_valid;
   logic rsp_ready;
   rsp_t rsp;

   modport manager (
      output req_valid,
      output req,
      input  req_ready,
      input  rsp_valid,
      input  rsp,
      output rsp_ready
   );

   modport subordinate (
      input  req_valid,
      input  req,
      output req_ready,
      output rsp_valid,
      output rsp,
      input  rsp_ready
   );

endinterface

// File: logic/bus_upsizer.sv
module bus_upsizer
   import bridge_pkg::*;
#(
   parameter int unsigned MaxPending = DefMaxPending
) (
   input logic            clk_i,
   input logic            arst_n_i,
   bus_if.subordinate     slv,
   bus_if.manager         mst
);

   localparam int unsigned PtrWidth = (MaxPending > 1) ? $clog2(MaxPending) : 1;
   localparam int unsigned CntWidth = $clog2(MaxPending + 1);

   logic [MaxPending-1:0] lane_q;
   logic [PtrWidth-1:0]   wr_ptr_q;
   logic [PtrWidth-1:0]   rd_ptr_q;
   logic [CntWidth-1:0]   count_q;
   logic                  full;
   logic                  push;
   logic                  pop;
   logic                  req_upper;
   logic                  rsp_upper;
   wide_req_t             wide_req;
   narrow_rsp_t           narrow_rsp;

   assign full      = (count_q == CntWidth'(MaxPending));
   assign req_upper = slv.req.addr[LaneBit];
   assign rsp_upper = lane_q[rd_ptr_q];

   assign mst.req_valid = slv.req_valid & ~full;
   assign slv.req_ready = mst.req_ready & ~full;
   assign push          = slv.req_valid & slv.req_ready;

   assign slv.rsp_valid = mst.rsp_valid;
   assign mst.rsp_ready = slv.rsp_ready;
   assign pop           = mst.rsp_valid & mst.rsp_ready;

   // Place narrow word and strobe into the addressed lane
   always_comb begin
      wide_req.addr  = slv.req.addr;
      wide_req.write = slv.req.write;
      if (req_upper) begin
         wide_req.data = {slv.req.data, {NarrowDataWidth{1'b0}}};
         wide_req.strb = {slv.req.strb, {(NarrowDataWidth/8){1'b0}}};
      end else begin
         wide_req.data = {{NarrowDataWidth{1'b0}}, slv.req.data};
         wide_req.strb = {{(NarrowDataWidth/8){1'b0}}, slv.req.strb};
      end
   end

   assign mst.req = wide_req;

   always_comb begin
      narrow_rsp.err  = mst.rsp.err;
      narrow_rsp.data = rsp_upper ? mst.rsp.data[WideDataWidth-1:NarrowDataWidth]
                                  : mst.rsp.data[NarrowDataWidth-1:0];
   end

   assign slv.rsp = narrow_rsp;

   // Lane records, oldest first
   always_ff @(posedge clk_i) begin
      if (push) begin
         lane_q[wr_ptr_q] <= req_upper;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PtrWidth'(MaxPending - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PtrWidth'(MaxPending - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         count_q <= count_q + CntWidth'(push) - CntWidth'(pop);
      end
   end

   a_lane_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      count_q <= CntWidth'(MaxPending));

   // A response never arrives without a recorded request
   a_lane_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      pop |-> (count_q != '0));

endmodule

// File: logic/bus_isolate.sv
module bus_isolate
   import bridge_pkg::*;
#(
   parameter int unsigned SyncStages = DefSyncStages,
   parameter int unsigned MaxPending = DefMaxPending
) (
   input logic        clk_i,
   input logic        arst_n_i,
   input logic        isolate_i,
   output logic       isolated_o,
   bus_if.subordinate slv,
   bus_if.manager     mst
);

   localparam int unsigned CntWidth = $clog2(MaxPending + 1);

   logic [SyncStages-1:0] iso_sync_q;
   logic                  isolate_sync;
   logic                  isolated_q;
   logic                  err_pending_q;
   logic [CntWidth-1:0]   pending_q;
   logic                  at_max;
   logic                  pass_en;
   logic                  mst_req_hs;
   logic                  mst_rsp_hs;
   logic                  term_req_hs;
   logic                  term_rsp_hs;
   wide_rsp_t             rsp;

   // Isolate request synchronizer, starts isolated
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         iso_sync_q <= '1;
      end else begin
         iso_sync_q <= {iso_sync_q[SyncStages-2:0], isolate_i};
      end
   end

   assign isolate_sync = iso_sync_q[SyncStages-1];

   assign at_max  = (pending_q == CntWidth'(MaxPending));
   assign pass_en = ~isolate_sync & ~isolated_q & ~err_pending_q & ~at_max;

   assign mst.req       = slv.req;
   assign mst.req_valid = slv.req_valid & pass_en;
   assign slv.req_ready = pass_en ? mst.req_ready
                                  : (slv.req_valid & isolated_q & ~err_pending_q);

   // Local error response takes over the response path
   assign slv.rsp_valid = err_pending_q | mst.rsp_valid;
   assign mst.rsp_ready = slv.rsp_ready & ~err_pending_q;

   always_comb begin
      rsp = mst.rsp;
      if (err_pending_q) begin
         rsp.data = '0;
         rsp.err  = 1'b1;
      end
   end

   assign slv.rsp = rsp;

   assign mst_req_hs  = mst.req_valid & mst.req_ready;
   assign mst_rsp_hs  = mst.rsp_valid & mst.rsp_ready;
   assign term_req_hs = slv.req_valid & slv.req_ready & ~pass_en;
   assign term_rsp_hs = err_pending_q & slv.rsp_ready;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pending_q     <= '0;
         isolated_q    <= 1'b1;
         err_pending_q <= 1'b0;
      end else begin
         pending_q  <= pending_q + CntWidth'(mst_req_hs) - CntWidth'(mst_rsp_hs);
         // Rise once drained, fall as soon as the request is withdrawn
         isolated_q <= isolate_sync & (isolated_q | (pending_q == '0));
         if (term_req_hs) begin
            err_pending_q <= 1'b1;
         end else if (term_rsp_hs) begin
            err_pending_q <= 1'b0;
         end
      end
   end

   assign isolated_o = isolated_q;

   a_pending_bounded: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (pending_q <= CntWidth'(MaxPending)) && (isolated_q -> (pending_q == '0)));

endmodule

// File: logic/cdc_fifo_src.sv
module cdc_fifo_src
   import bridge_pkg::*;
#(
   parameter type         payload_t  = wide_req_t,
   parameter int unsigned LogDepth   = DefLogDepth,
   parameter int unsigned SyncStages = DefSyncStages
) (
   input logic                            clk_i,
   input logic                            arst_n_i,
   input logic                            valid_i,
   output logic                           ready_o,
   input payload_t                        data_i,
   output payload_t [2**LogDepth-1:0]     async_data_o,
   output logic [LogDepth:0]              async_wptr_o,
   input logic [LogDepth:0]               async_rptr_i
);

   // Full when the pointers differ only in their two top bits
   localparam logic [LogDepth:0] TopMask = (LogDepth + 1)'(3) << (LogDepth - 1);

   payload_t [2**LogDepth-1:0]        mem_q;
   logic [LogDepth:0]                 wptr_bin_q;
   logic [LogDepth:0]                 wptr_gray_q;
   logic [LogDepth:0]                 wptr_bin_next;
   logic [SyncStages-1:0][LogDepth:0] rptr_sync_q;
   logic                              full;
   logic                              push;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rptr_sync_q <= '0;
      end else begin
         rptr_sync_q <= {rptr_sync_q[SyncStages-2:0], async_rptr_i};
      end
   end

   assign full          = (wptr_gray_q == (rptr_sync_q[SyncStages-1] ^ TopMask));
   assign ready_o       = ~full;
   assign push          = valid_i & ~full;
   assign wptr_bin_next = wptr_bin_q + 1'b1;

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wptr_bin_q[LogDepth-1:0]] <= data_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wptr_bin_q  <= '0;
         wptr_gray_q <= '0;
      end else if (push) begin
         wptr_bin_q  <= wptr_bin_next;
         wptr_gray_q <= wptr_bin_next ^ (wptr_bin_next >> 1);
      end
   end

   assign async_data_o = mem_q;
   assign async_wptr_o = wptr_gray_q;

   // A request refused while full stays offered until it is written
   a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (valid_i && full) |=> (valid_i && $stable(data_i)));

endmodule

// File: logic/cdc_fifo_dst.sv
module cdc_fifo_dst
   import bridge_pkg::*;
#(
   parameter type         payload_t  = wide_rsp_t,
   parameter int unsigned LogDepth   = DefLogDepth,
   parameter int unsigned SyncStages = DefSyncStages
) (
   input logic                            clk_i,
   input logic                            arst_n_i,
   output logic                           valid_o,
   input logic                            ready_i,
   output payload_t                       data_o,
   input payload_t [2**LogDepth-1:0]      async_data_i,
   input logic [LogDepth:0]               async_wptr_i,
   output logic [LogDepth:0]              async_rptr_o
);

   logic [LogDepth:0]                 rptr_bin_q;
   logic [LogDepth:0]                 rptr_gray_q;
   logic [LogDepth:0]                 rptr_bin_next;
   logic [SyncStages-1:0][LogDepth:0] wptr_sync_q;
   logic                              pop;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wptr_sync_q <= '0;
      end else begin
         wptr_sync_q <= {wptr_sync_q[SyncStages-2:0], async_wptr_i};
      end
   end

   // Not empty while the far writer is ahead
   assign valid_o       = (wptr_sync_q[SyncStages-1] != rptr_gray_q);
   assign data_o        = async_data_i[rptr_bin_q[LogDepth-1:0]];
   assign pop           = valid_o & ready_i;
   assign rptr_bin_next = rptr_bin_q + 1'b1;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rptr_bin_q  <= '0;
         rptr_gray_q <= '0;
      end else if (pop) begin
         rptr_bin_q  <= rptr_bin_next;
         rptr_gray_q <= rptr_bin_next ^ (rptr_bin_next >> 1);
      end
   end

   assign async_rptr_o = rptr_gray_q;

   // Far side must not overwrite an entry it has not seen popped
   a_data_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (valid_o && !ready_i) |=> $stable(data_o));

endmodule

// File: logic/secure_bus_bridge.sv
module secure_bus_bridge
   import bridge_pkg::*;
#(
   parameter int unsigned LogDepth   = DefLogDepth,
   parameter int unsigned SyncStages = DefSyncStages,
   parameter int unsigned MaxPending = DefMaxPending
) (
   input logic                          clk_i,
   input logic                          arst_n_i,
   // Narrow bus from the core
   input logic                          req_valid_i,
   output logic                         req_ready_o,
   input addr_t                         req_addr_i,
   input logic                          req_write_i,
   input narrow_data_t                  req_wdata_i,
   input narrow_strb_t                  req_strb_i,
   output logic                         rsp_valid_o,
   input logic                          rsp_ready_i,
   output narrow_data_t                 rsp_rdata_o,
   output logic                         rsp_err_o,
   // Isolation control
   input logic                          isolate_i,
   output logic                         isolated_o,
   // Async port
   output wide_req_t [2**LogDepth-1:0]  async_req_data_o,
   output logic [LogDepth:0]            async_req_wptr_o,
   input logic [LogDepth:0]             async_req_rptr_i,
   input wide_rsp_t [2**LogDepth-1:0]   async_rsp_data_i,
   input logic [LogDepth:0]             async_rsp_wptr_i,
   output logic [LogDepth:0]            async_rsp_rptr_o
);

   bus_if #(.req_t(narrow_req_t), .rsp_t(narrow_rsp_t)) narrow_bus ();
   bus_if #(.req_t(wide_req_t),   .rsp_t(wide_rsp_t))   wide_bus ();
   bus_if #(.req_t(wide_req_t),   .rsp_t(wide_rsp_t))   iso_bus ();

   assign narrow_bus.req_valid = req_valid_i;
   assign narrow_bus.req       = narrow_req_t'{
      addr:  req_addr_i,
      write: req_write_i,
      data:  req_wdata_i,
      strb:  req_strb_i
   };
   assign req_ready_o          = narrow_bus.req_ready;

   assign rsp_valid_o          = narrow_bus.rsp_valid;
   assign rsp_rdata_o          = narrow_bus.rsp.data;
   assign rsp_err_o            = narrow_bus.rsp.err;
   assign narrow_bus.rsp_ready = rsp_ready_i;

   bus_upsizer #(
      .MaxPending ( MaxPending )
   ) u_bus_upsizer (
      .clk_i,
      .arst_n_i,
      .slv ( narrow_bus ),
      .mst ( wide_bus   )
   );

   bus_isolate #(
      .SyncStages ( SyncStages ),
      .MaxPending ( MaxPending )
   ) u_bus_isolate (
      .clk_i,
      .arst_n_i,
      .isolate_i,
      .isolated_o,
      .slv ( wide_bus ),
      .mst ( iso_bus  )
   );

   // Source half of the clock-domain crossing
   cdc_fifo_src #(
      .payload_t  ( wide_req_t ),
      .LogDepth   ( LogDepth   ),
      .SyncStages ( SyncStages )
   ) u_req_fifo (
      .clk_i,
      .arst_n_i,
      .valid_i      ( iso_bus.req_valid ),
      .ready_o      ( iso_bus.req_ready ),
      .data_i       ( iso_bus.req       ),
      .async_data_o ( async_req_data_o  ),
      .async_wptr_o ( async_req_wptr_o  ),
      .async_rptr_i ( async_req_rptr_i  )
   );

   cdc_fifo_dst #(
      .payload_t  ( wide_rsp_t ),
      .LogDepth   ( LogDepth   ),
      .SyncStages ( SyncStages )
   ) u_rsp_fifo (
      .clk_i,
      .arst_n_i,
      .valid_o      ( iso_bus.rsp_valid ),
      .ready_i      ( iso_bus.rsp_ready ),
      .data_o       ( iso_bus.rsp       ),
      .async_data_i ( async_rsp_data_i  ),
      .async_wptr_i ( async_rsp_wptr_i  ),
      .async_rptr_o ( async_rsp_rptr_o  )
   );

endmodule

// File: verification/tb_bridge_tasks.svh
`ifndef TB_BRIDGE_TASKS_SVH
`define TB_BRIDGE_TASKS_SVH

task automatic report_mismatch(string msg);
   $display("ERR @%0t: %s", $time, msg);
   $display("*** TEST FAILED ***");
   $fatal(1, "value mismatch");
endtask

task automatic compare_rdata(narrow_data_t got, narrow_data_t exp, string what);
   if (got !== exp) begin
      report_mismatch($sformatf("%s is 0x%08h, expected 0x%08h", what, got, exp));
   end
endtask

task automatic compare_flag(logic got, logic exp, string what);
   if (got !== exp) begin
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
   end
endtask

task automatic compare_ptr(ptr_t got, ptr_t exp, string what);
   if (got !== exp) begin
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
   end
endtask

task automatic compare_strb(wide_strb_t got, wide_strb_t exp, string what);
   if (got !== exp) begin
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
   end
endtask

function automatic narrow_data_t merge_bytes(narrow_data_t old, narrow_data_t wdata,
                                             narrow_strb_t strb);
   narrow_data_t res;
   int           b;
   res = old;
   for (b = 0; b < 4; b++) begin
      if (strb[b]) begin
         res[8*b +: 8] = wdata[8*b +: 8];
      end
   end
   return res;
endfunction

// Presents a request and records the response it should get
task automatic drive_req(addr_t addr, logic write, narrow_data_t wdata, narrow_strb_t strb,
                         logic iso);
   int idx;
   @(negedge clk_i);
   idx         = int'(addr[6:2]);
   req_valid_i = 1'b1;
   req_addr_i  = addr;
   req_write_i = write;
   req_wdata_i = wdata;
   req_strb_i  = strb;
   if (iso) begin
      exp_data_q.push_back('0);
      exp_err_q.push_back(1'b1);
   end else begin
      if (write) begin
         ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, strb);
         exp_data_q.push_back('0);
      end else begin
         exp_data_q.push_back(ref_mem[idx]);
      end
      exp_err_q.push_back(1'b0);
   end
endtask

task automatic wait_accept();
   do begin
      @(posedge clk_i);
   end while (!req_ready_o);
   @(negedge clk_i);
   req_valid_i = 1'b0;
endtask

task automatic issue_req(addr_t addr, logic write, narrow_data_t wdata, narrow_strb_t strb,
                         logic iso);
   drive_req(addr, write, wdata, strb, iso);
   wait_accept();
endtask

task automatic check_rsps(int count);
   narrow_data_t got;
   logic         got_err;
   int           n;
   for (n = 0; n < count; n++) begin
      while (rsp_data_q.size() == 0) begin
         @(negedge clk_i);
      end
      got     = rsp_data_q.pop_front();
      got_err = rsp_err_q.pop_front();
      compare_flag(got_err, exp_err_q.pop_front(), "response err");
      compare_rdata(got, exp_data_q.pop_front(), "response data");
   end
endtask

task automatic wait_isolated(logic level);
   while (isolated_o !== level) begin
      @(negedge clk_i);
   end
endtask

task automatic test_reset_release();
   compare_flag(isolated_o, 1'b1, "isolated_o after reset");
   compare_flag(req_ready_o, 1'b0, "req_ready_o after reset");
   compare_flag(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
   compare_ptr(async_req_wptr_o, '0, "request write pointer after reset");
   compare_ptr(async_rsp_rptr_o, '0, "response read pointer after reset");
   @(negedge clk_i);
   isolate_i = 1'b0;
   wait_isolated(1'b0);
   compare_flag(req_ready_o, 1'b1, "req_ready_o after release");
endtask

task automatic test_lane_select();
   issue_req(32'h10, 1'b1, 32'h1234_5678, 4'hf, 1'b0);
   check_rsps(1);
   compare_strb(far_last_req.strb, 8'h0f, "lower lane strobe");
   compare_rdata(far_last_req.data[31:0], 32'h1234_5678, "lower lane data");
   issue_req(32'h10, 1'b0, '0, '0, 1'b0);
   check_rsps(1);
   issue_req(32'h14, 1'b1, 32'h9abc_def0, 4'hf, 1'b0);
   check_rsps(1);
   compare_strb(far_last_req.strb, 8'hf0, "upper lane strobe");
   compare_rdata(far_last_req.data[63:32], 32'h9abc_def0, "upper lane data");
   issue_req(32'h14, 1'b0, '0, '0, 1'b0);
   check_rsps(1);
endtask

task automatic test_partial_strobe();
   issue_req(32'h20, 1'b1, 32'h1122_3344, 4'hf, 1'b0);
   issue_req(32'h20, 1'b1, 32'haabb_ccdd, 4'b0101, 1'b0);
   issue_req(32'h20, 1'b0, '0, '0, 1'b0);
   check_rsps(3);
endtask

task automatic test_backpressure();
   ptr_t wptr_hold;
   int   n;
   @(negedge clk_i);
   far_stall = 1'b1;
   issue_req(32'h50, 1'b1, 32'hcafe_0001, 4'hf, 1'b0);
   issue_req(32'h54, 1'b1, 32'hcafe_0002, 4'hf, 1'b0);
   issue_req(32'h50, 1'b0, '0, '0, 1'b0);
   issue_req(32'h54, 1'b0, '0, '0, 1'b0);
   wptr_hold = async_req_wptr_o;
   drive_req(32'h58, 1'b0, '0, '0, 1'b0);
   for (n = 0; n < 12; n++) begin
      @(negedge clk_i);
      compare_flag(req_ready_o, 1'b0, "req_ready_o with request FIFO full");
   end
   compare_ptr(async_req_wptr_o, wptr_hold, "request write pointer while stalled");
   far_stall = 1'b0;
   wait_accept();
   check_rsps(5);
endtask

task automatic test_isolate();
   ptr_t wptr_hold;
   @(negedge clk_i);
   far_stall = 1'b1;
   issue_req(32'h40, 1'b0, '0, '0, 1'b0);
   issue_req(32'h44, 1'b0, '0, '0, 1'b0);
   isolate_i = 1'b1;
   repeat (DefSyncStages + 5) @(negedge clk_i);
   compare_flag(isolated_o, 1'b0, "isolated_o with reads outstanding");
   far_stall = 1'b0;
   check_rsps(2);
   wait_isolated(1'b1);
   wptr_hold = async_req_wptr_o;
   issue_req(32'h48, 1'b0, '0, '0, 1'b1);
   check_rsps(1);
   compare_ptr(async_req_wptr_o, wptr_hold, "request write pointer while isolated");
   isolate_i = 1'b0;
   wait_isolated(1'b0);
endtask

task automatic test_random();
   addr_t        addr;
   logic         write;
   narrow_data_t wdata;
   narrow_strb_t strb;
   int           n;
   for (n = 0; n < RandOps; n++) begin
      addr  = addr_t'($random(seed)) & 32'h0000_007c;
      write = 1'($random(seed));
      wdata = narrow_data_t'($random(seed));
      strb  = 4'($random(seed));
      issue_req(addr, write, wdata, strb, 1'b0);
      check_rsps(1);
   end
endtask

`endif

// File: verification/tb_secure_bus_bridge.sv
module tb_secure_bus_bridge
   import bridge_pkg::*;
();

   localparam int unsigned LogDepth       = DefLogDepth;
   localparam int unsigned Depth          = 2**LogDepth;
   localparam int unsigned NumTests       = 6;
   localparam int unsigned RandOps        = 50;
   localparam int unsigned WatchdogCycles = 16 + NumTests * 200 + RandOps * 20;

   typedef logic [LogDepth:0] ptr_t;

   // Full when the pointers differ only in their two top bits
   localparam ptr_t FullMask = ptr_t'(3) << (LogDepth - 1);

   logic                   clk_i;
   logic                   arst_n_i;
   logic                   req_valid_i;
   logic                   req_ready_o;
   addr_t                  req_addr_i;
   logic                   req_write_i;
   narrow_data_t           req_wdata_i;
   narrow_strb_t           req_strb_i;
   logic                   rsp_valid_o;
   logic                   rsp_ready_i;
   narrow_data_t           rsp_rdata_o;
   logic                   rsp_err_o;
   logic                   isolate_i;
   logic                   isolated_o;
   wide_req_t [Depth-1:0]  async_req_data_o;
   ptr_t                   async_req_wptr_o;
   ptr_t                   async_req_rptr_i;
   wide_rsp_t [Depth-1:0]  async_rsp_data_i;
   ptr_t                   async_rsp_wptr_i;
   ptr_t                   async_rsp_rptr_o;

   // Far-side model state
   wide_data_t             far_mem [16];
   wide_req_t              far_last_req;
   ptr_t                   far_rd_bin;
   ptr_t                   far_wr_bin;
   logic                   far_stall;

   // Reference memory, one narrow word per address bits 6:2
   narrow_data_t           ref_mem [32];
   narrow_data_t           exp_data_q [$];
   logic                   exp_err_q [$];
   narrow_data_t           rsp_data_q [$];
   logic                   rsp_err_q [$];
   integer                 seed;

   secure_bus_bridge u_secure_bus_bridge (.*);

   always #5 clk_i = ~clk_i;

   assign async_req_rptr_i = far_rd_bin ^ (far_rd_bin >> 1);
   assign async_rsp_wptr_i = far_wr_bin ^ (far_wr_bin >> 1);

   function automatic wide_data_t fill_word(int idx);
      return {16{4'(idx)}} ^ 64'h3c5a_96f0_0f69_a5c3;
   endfunction

   // Consumes at most one request per cycle, in order
   always @(posedge clk_i or negedge arst_n_i) begin
      wide_req_t  req;
      wide_rsp_t  rsp;
      wide_data_t word;
      int         idx;
      int         b;
      if (!arst_n_i) begin
         far_rd_bin <= '0;
         far_wr_bin <= '0;
      end else if (!far_stall && (async_req_rptr_i != async_req_wptr_o) &&
                   (async_rsp_wptr_i != (async_rsp_rptr_o ^ FullMask))) begin
         req  = async_req_data_o[far_rd_bin[LogDepth-1:0]];
         idx  = int'(req.addr[6:3]);
         word = far_mem[idx];
         for (b = 0; b < 8; b++) begin
            if (req.strb[b]) begin
               word[8*b +: 8] = req.data[8*b +: 8];
            end
         end
         rsp.err  = 1'b0;
         rsp.data = req.write ? '0 : far_mem[idx];
         if (req.write) begin
            far_mem[idx] <= word;
         end
         async_rsp_data_i[far_wr_bin[LogDepth-1:0]] <= rsp;
         far_last_req <= req;
         far_rd_bin   <= far_rd_bin + 1'b1;
         far_wr_bin   <= far_wr_bin + 1'b1;
      end
   end

   always @(posedge clk_i) begin
      if (arst_n_i && rsp_valid_o && rsp_ready_i) begin
         rsp_data_q.push_back(rsp_rdata_o);
         rsp_err_q.push_back(rsp_err_o);
      end
   end

   `include "tb_bridge_tasks.svh"

   initial begin
      repeat (WatchdogCycles) @(posedge clk_i);
      $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
      $display("*** TEST FAILED ***");
      $fatal(1, "watchdog expired");
   end

   initial begin
      wide_data_t init_word;
      seed        = 32'hb354;
      clk_i       = 1'b0;
      arst_n_i    = 1'b0;
      req_valid_i = 1'b0;
      req_addr_i  = '0;
      req_write_i = 1'b0;
      req_wdata_i = '0;
      req_strb_i  = '0;
      rsp_ready_i = 1'b1;
      isolate_i   = 1'b1;
      far_stall   = 1'b0;
      far_rd_bin       <= '0;
      far_wr_bin       <= '0;
      async_rsp_data_i <= '0;
      for (int i = 0; i < 16; i++) begin
         init_word      = fill_word(i);
         far_mem[i]     <= init_word;
         ref_mem[2*i]   = init_word[31:0];
         ref_mem[2*i+1] = init_word[63:32];
      end
      repeat (16) @(negedge clk_i);
      arst_n_i = 1'b1;

      test_reset_release();
      test_lane_select();
      test_partial_strobe();
      test_backpressure();
      test_isolate();
      test_random();

      if (exp_data_q.size() == 0 && rsp_data_q.size() == 0) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         $display("Responses left unmatched at the end of the run");
         $display("*** TEST FAILED ***");
         $fatal(1, "unmatched responses");
      end
   end

endmodule

// File: compile.f
+incdir+verification
logic/bridge_pkg.sv
logic/bus_if.sv
logic/bus_upsizer.sv
logic/bus_isolate.sv
logic/cdc_fifo_src.sv
logic/cdc_fifo_dst.sv
logic/secure_bus_bridge.sv
verification/tb_secure_bus_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_secure_bus_bridge
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verification/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
